/* hdl/cbusPkg.sv */
// shared widths, encodings and memory map for the cache-bus subsystem
package cbusPkg;

	// bus widths
	localparam int AddrW = 64;
	localparam int DataW = 64;
	localparam int StrbW = 8;
	localparam int ByteW = 8;

	// byte lane select inside one data word
	localparam int LaneW = $clog2(StrbW);

	// burst length field holds beats minus one
	localparam int LenW = 3;

	// word-addressed RAM, 1024 words
	localparam int RamIdxW = 10;
	localparam int RamDepth = 1 << RamIdxW;

	// memory map
	localparam logic [AddrW-1:0] UartAddr = 64'h0000_0000_4060_0004;
	localparam int RamBit = 31;

	// target of a request, decoded from its address
	typedef enum logic [1:0] {
		RegRam  = 2'd0,
		RegUart = 2'd1,
		RegNone = 2'd2
	} region_e;

	// control FSM states
	// RAM reads alternate StRdAddr/StRdData per beat,
	// RAM writes stay in StWrite one cycle per beat
	typedef enum logic [2:0] {
		StIdle   = 3'd0,
		StRdAddr = 3'd1,
		StRdData = 3'd2,
		StWrite  = 3'd3,
		StSingle = 3'd4,
		StDone   = 3'd5
	} state_e;

endpackage

/* hdl/busCtrl.sv */
`timescale 1ns/100ps

// beat sequencer for cache-bus requests
// drives RAM strobes and the ready/last/err response
module busCtrl (
	input  logic                     aclk,
	input  logic                     arstN,
	input  logic                     reqValid,
	input  logic                     reqIsWrite,
	input  logic [cbusPkg::LenW-1:0] reqLen,
	input  cbusPkg::region_e         region,
	output logic [cbusPkg::LenW-1:0] beatCnt,
	output logic                     ramEn,
	output logic                     ramWe,
	output logic                     respReady,
	output logic                     respLast,
	output logic                     respErr,
	output logic                     uartValid
);

	cbusPkg::state_e          state;
	cbusPkg::state_e          stateNext;
	cbusPkg::region_e         regionQ;
	logic [cbusPkg::LenW-1:0] lenQ;
	logic                     lastBeat;
	logic                     beatDone;

	// beat counter reached the captured length
	assign lastBeat = (beatCnt == lenQ);

	// a beat completes in every cycle with ready high
	assign beatDone = respReady;

	always_comb begin
		stateNext = state;
		case (state)
			cbusPkg::StIdle: begin
				if (reqValid) begin
					if (region != cbusPkg::RegRam) begin
						stateNext = cbusPkg::StSingle;
					end else if (reqIsWrite) begin
						stateNext = cbusPkg::StWrite;
					end else begin
						stateNext = cbusPkg::StRdAddr;
					end
				end
			end
			// read issued here, data registered by the RAM at the edge
			cbusPkg::StRdAddr: stateNext = cbusPkg::StRdData;
			cbusPkg::StRdData: begin
				stateNext = lastBeat ? cbusPkg::StDone : cbusPkg::StRdAddr;
			end
			cbusPkg::StWrite: begin
				if (lastBeat) begin
					stateNext = cbusPkg::StDone;
				end
			end
			cbusPkg::StSingle: stateNext = cbusPkg::StDone;
			// one dead cycle so the master can drop reqValid
			cbusPkg::StDone: stateNext = cbusPkg::StIdle;
			default: stateNext = cbusPkg::StIdle;
		endcase
	end

	always_ff @(posedge aclk or negedge arstN) begin
		if (!arstN) begin
			state   <= cbusPkg::StIdle;
			regionQ <= cbusPkg::RegNone;
			lenQ    <= '0;
			beatCnt <= '0;
		end else begin
			state <= stateNext;
			if (state == cbusPkg::StIdle && reqValid) begin
				regionQ <= region;
				beatCnt <= '0;
				// console and unmapped space always get one beat
				if (region == cbusPkg::RegRam) begin
					lenQ <= reqLen;
				end else begin
					lenQ <= '0;
				end
			end else if (beatDone && !lastBeat) begin
				beatCnt <= beatCnt + cbusPkg::LenW'(1);
			end
		end
	end

	// RAM strobes
	always_comb begin
		ramEn = (state == cbusPkg::StRdAddr) || (state == cbusPkg::StWrite);
		ramWe = (state == cbusPkg::StWrite);
	end

	// response strobes, decoded from the registered state
	always_comb begin
		respReady = (state == cbusPkg::StRdData) ||
			(state == cbusPkg::StWrite) ||
			(state == cbusPkg::StSingle);
		respLast = respReady && lastBeat;
		respErr = (state == cbusPkg::StSingle) && (regionQ == cbusPkg::RegNone);
		// reqIsWrite is still held stable by the master in StSingle
		uartValid = (state == cbusPkg::StSingle) &&
			(regionQ == cbusPkg::RegUart) && reqIsWrite;
	end

endmodule

/* hdl/addrMap.sv */
`timescale 1ns/100ps

// address decode for the cache bus
// region, RAM word index per beat, console byte lane
module addrMap (
	input  logic [cbusPkg::AddrW-1:0]   reqAddr,
	input  logic [cbusPkg::DataW-1:0]   reqData,
	input  logic [cbusPkg::LenW-1:0]    beatCnt,
	output cbusPkg::region_e            region,
	output logic [cbusPkg::RamIdxW-1:0] ramIdx,
	output logic [cbusPkg::ByteW-1:0]   uartChar
);

	logic [cbusPkg::RamIdxW-1:0] baseIdx;
	logic [cbusPkg::LaneW-1:0]   lane;
	logic                        isUart;
	logic                        isRam;

	assign isUart = (reqAddr == cbusPkg::UartAddr);
	assign isRam = reqAddr[cbusPkg::RamBit];

	// exact console match wins over the RAM bit
	always_comb begin
		if (isUart) begin
			region = cbusPkg::RegUart;
		end else if (isRam) begin
			region = cbusPkg::RegRam;
		end else begin
			region = cbusPkg::RegNone;
		end
	end

	// word index is address bits 12..3
	assign baseIdx = reqAddr[cbusPkg::LaneW +: cbusPkg::RamIdxW];

	// incrementing burst, wraps at the RAM depth
	assign ramIdx = baseIdx + cbusPkg::RamIdxW'(beatCnt);

	// byte lane from the low address bits
	assign lane = reqAddr[cbusPkg::LaneW-1:0];
	assign uartChar = reqData[lane * cbusPkg::ByteW +: cbusPkg::ByteW];

endmodule

/* hdl/ramHelper.sv */
`timescale 1ns/100ps

// single-port word RAM, byte strobes on write, registered read
module ramHelper (
	input  logic                        aclk,
	input  logic                        en,
	input  logic                        we,
	input  logic [cbusPkg::RamIdxW-1:0] idx,
	input  logic [cbusPkg::DataW-1:0]   wdata,
	input  logic [cbusPkg::StrbW-1:0]   strobe,
	output logic [cbusPkg::DataW-1:0]   rdata
);

	logic [cbusPkg::DataW-1:0] mem [cbusPkg::RamDepth];

	// write side, one byte lane per strobe bit
	always_ff @(posedge aclk) begin
		if (en && we) begin
			for (int b = 0; b < cbusPkg::StrbW; b++) begin
				if (strobe[b]) begin
					mem[idx][b * cbusPkg::ByteW +: cbusPkg::ByteW] <=
						wdata[b * cbusPkg::ByteW +: cbusPkg::ByteW];
				end
			end
		end
	end

	// read side, data appears the cycle after the enable
	// and holds until the next read
	always_ff @(posedge aclk) begin
		if (en && !we) begin
			rdata <= mem[idx];
		end
	end

endmodule

/* hdl/memTop.sv */
`timescale 1ns/100ps

// memory-side cache-bus subsystem
// RAM region, console port, error response for the rest
module memTop (
	input  logic                      aclk,
	input  logic                      arstN,

	// request from the master
	input  logic                      reqValid,
	input  logic                      reqIsWrite,
	input  logic [cbusPkg::AddrW-1:0] reqAddr,
	input  logic [cbusPkg::LenW-1:0]  reqLen,
	input  logic [cbusPkg::StrbW-1:0] reqStrobe,
	input  logic [cbusPkg::DataW-1:0] reqData,

	// response to the master
	output logic                      respReady,
	output logic                      respLast,
	output logic                      respErr,
	output logic [cbusPkg::DataW-1:0] respData,

	// console character out
	output logic                      uartValid,
	output logic [cbusPkg::ByteW-1:0] uartChar
);

	cbusPkg::region_e            region;
	logic [cbusPkg::LenW-1:0]    beatCnt;
	logic [cbusPkg::RamIdxW-1:0] ramIdx;
	logic                        ramEn;
	logic                        ramWe;
	logic [cbusPkg::DataW-1:0]   ramRdata;

	busCtrl ctrl_i (
		.aclk      (aclk),
		.arstN     (arstN),
		.reqValid  (reqValid),
		.reqIsWrite(reqIsWrite),
		.reqLen    (reqLen),
		.region    (region),
		.beatCnt   (beatCnt),
		.ramEn     (ramEn),
		.ramWe     (ramWe),
		.respReady (respReady),
		.respLast  (respLast),
		.respErr   (respErr),
		.uartValid (uartValid)
	);

	addrMap map_i (
		.reqAddr (reqAddr),
		.reqData (reqData),
		.beatCnt (beatCnt),
		.region  (region),
		.ramIdx  (ramIdx),
		.uartChar(uartChar)
	);

	ramHelper ram_i (
		.aclk  (aclk),
		.en    (ramEn),
		.we    (ramWe),
		.idx   (ramIdx),
		.wdata (reqData),
		.strobe(reqStrobe),
		.rdata (ramRdata)
	);

	// unmapped accesses read as zero
	assign respData = respErr ? '0 : ramRdata;

endmodule

/* test/memTop_props.sv */
`timescale 1ns/100ps

// protocol rules on the response strobes of the control FSM
module memTop_props (
	input logic             aclk,
	input logic             arstN,
	input cbusPkg::state_e  state,
	input logic             respReady,
	input logic             respLast,
	input logic             respErr,
	input logic             uartValid
);

	// no beat completes while waiting for a request
	idleQuiet: assert property (@(posedge aclk) disable iff (!arstN)
		(state == cbusPkg::StIdle) |-> !respReady)
		else $error("respReady high while the FSM is idle");

	lastWithReady: assert property (@(posedge aclk) disable iff (!arstN)
		respLast |-> respReady)
		else $error("respLast high without respReady");

	// console pulse only on a good completed beat
	uartOnGoodBeat: assert property (@(posedge aclk) disable iff (!arstN)
		uartValid |-> (respReady && !respErr))
		else $error("uartValid outside a good ready beat");

endmodule

// attached to the control FSM, where the state register lives
bind busCtrl memTop_props props_i (
	.aclk     (aclk),
	.arstN    (arstN),
	.state    (state),
	.respReady(respReady),
	.respLast (respLast),
	.respErr  (respErr),
	.uartValid(uartValid)
);

/* test/memTb.sv */
`timescale 1ns/100ps

// random bus traffic checked against a word-array model of the RAM
module memTb;

	logic        aclk;
	logic        arstN;
	logic        reqValid;
	logic        reqIsWrite;
	logic [63:0] reqAddr;
	logic [2:0]  reqLen;
	logic [7:0]  reqStrobe;
	logic [63:0] reqData;
	logic        respReady;
	logic        respLast;
	logic        respErr;
	logic [63:0] respData;
	logic        uartValid;
	logic [7:0]  uartChar;

	// reference copy of all 1024 RAM words
	logic [63:0] model [1024];
	integer      seed;

	memTop dut_i (.*);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	function automatic logic [31:0] rnd32();
		rnd32 = $random(seed);
	endfunction

	function automatic logic [63:0] rnd64();
		rnd64 = {rnd32(), rnd32()};
	endfunction

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic verifyThat(input logic ok, input string what);
		assert (ok) else begin
			stopWithFailure($sformatf("[FAIL] %0t ns: %s", $time, what));
		end
	endtask

	// returns at the falling edge where respReady is seen high
	task automatic waitReady(output int waited);
		logic ready;
		waited = 0;
		ready = 1'b0;
		while (!ready) begin
			@(negedge aclk);
			waited++;
			ready = respReady;
			if (!ready && waited >= 64) begin
				stopWithFailure("timeout: no respReady within 64 cycles");
			end
		end
	endtask

	// new data and strobes for the next write beat
	task automatic driveBeat(input logic isWrite, input logic allBytes);
		logic [31:0] r;
		r = rnd32();
		reqData = rnd64();
		reqStrobe = !isWrite ? 8'h00 : (allBytes ? 8'hff : r[7:0]);
	endtask

	// one full request, every beat checked; called at a falling edge
	task automatic runRequest(input logic isWrite, input logic [63:0] addr,
			input logic [2:0] len, input logic allBytes);
		logic        isUart;
		logic        isRam;
		int          beats;
		int          expWait;
		int          waited;
		logic [9:0]  idx;
		logic [63:0] mask;
		logic [63:0] expData;
		logic        gotLast;
		logic        gotErr;
		logic        gotUart;
		logic [7:0]  gotChar;
		logic [63:0] gotData;
		isUart = (addr == 64'h0000_0000_4060_0004);
		isRam = !isUart && addr[31];
		beats = isRam ? int'(len) + 1 : 1;
		// RAM reads need an address cycle before every data beat
		expWait = (isRam && !isWrite) ? 2 : 1;
		reqValid = 1'b1;
		reqIsWrite = isWrite;
		reqAddr = addr;
		reqLen = len;
		driveBeat(isWrite, allBytes);
		for (int k = 0; k < beats; k++) begin
			waitReady(waited);
			gotLast = respLast;
			gotErr = respErr;
			gotUart = uartValid;
			gotChar = uartChar;
			gotData = respData;
			verifyThat(waited == expWait, $sformatf("beat %0d ready after %0d cycles, expected %0d",
				k, waited, expWait));
			verifyThat(gotLast == (k == beats - 1), $sformatf("respLast=%0b on beat %0d of %0d",
				gotLast, k, beats));
			verifyThat(gotErr == (!isRam && !isUart),
				$sformatf("respErr=%0b for address %h", gotErr, addr));
			verifyThat(gotUart == (isUart && isWrite), "uartValid wrong on this beat");
			if (isUart && isWrite) begin
				// console address sits in byte lane 4
				verifyThat(gotChar == reqData[39:32],
					$sformatf("uartChar %h, data %h", gotChar, reqData));
			end
			// a write beat after the first takes its data now
			if (isWrite && k > 0) begin
				driveBeat(isWrite, allBytes);
			end
			idx = addr[12:3] + 10'(k);
			if (!isWrite) begin
				expData = isRam ? model[idx] : 64'h0;
				verifyThat(gotData == expData, $sformatf("read word %0d got %h, expected %h",
					idx, gotData, expData));
			end else if (isRam) begin
				for (int b = 0; b < 8; b++) begin
					mask[8 * b +: 8] = {8{reqStrobe[b]}};
				end
				model[idx] = (model[idx] & ~mask) | (reqData & mask);
			end
		end
		// FSM sits in StDone here, no further beat allowed
		@(negedge aclk);
		verifyThat(!respReady, "extra ready pulse after the last beat");
		reqValid = 1'b0;
		@(negedge aclk);
		verifyThat(!respReady && !uartValid, "response active after request dropped");
	endtask

	initial begin
		logic [31:0] r;
		logic [63:0] addr;
		seed = 32'h1389f026;
		arstN = 1'b0;
		reqValid = 1'b0;
		reqIsWrite = 1'b0;
		reqAddr = '0;
		reqLen = '0;
		reqStrobe = '0;
		reqData = '0;
		repeat (5) @(posedge aclk);
		@(negedge aclk);
		arstN = 1'b1;
		// quiet bus after reset
		repeat (10) begin
			@(negedge aclk);
			verifyThat(!respReady && !respLast && !uartValid, "response active on an idle bus");
		end
		// preload every RAM word with full strobes
		for (int i = 0; i < 128; i++) begin
			runRequest(1'b1, 64'h8000_0000 + 64'(i * 64), 3'd7, 1'b1);
		end
		// burst across the top of the RAM
		runRequest(1'b1, 64'h8000_1fe8, 3'd7, 1'b0);
		runRequest(1'b0, 64'h8000_1fe8, 3'd7, 1'b0);
		for (int n = 0; n < 300; n++) begin
			r = rnd32();
			addr = rnd64();
			case (r[7:5])
				3'd0, 3'd1, 3'd2: begin
					addr[31] = 1'b1;
					runRequest(1'b1, addr, r[2:0], 1'b0);
				end
				3'd3, 3'd4, 3'd5: begin
					addr[31] = 1'b1;
					runRequest(1'b0, addr, r[2:0], 1'b0);
				end
				3'd6: runRequest(1'b1, 64'h0000_0000_4060_0004, r[2:0], 1'b0);
				default: begin
					addr[31] = 1'b0;
					if (addr == 64'h0000_0000_4060_0004) begin
						addr[3] = 1'b1;
					end
					runRequest(r[8], addr, r[2:0], 1'b0);
				end
			endcase
		end
		// console and unmapped writes must have left the RAM alone
		for (int i = 0; i < 128; i++) begin
			runRequest(1'b0, 64'h8000_0000 + 64'(i * 64), 3'd7, 1'b0);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

/* src.f */
hdl/cbusPkg.sv
hdl/busCtrl.sv
hdl/addrMap.sv
hdl/ramHelper.sv
hdl/memTop.sv
test/memTop_props.sv
test/memTb.sv

/* Makefile */
# Verilator build and run for the cache-bus memory subsystem

VERILATOR ?= verilator
TOP       ?= memTb
FLIST     ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

# pass or fail is decided by the pass message in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
